// ==== common/timer_pkg.sv ====
//**********************************************************************
// Shared widths, address map and encodings of the timer peripheral.
// Word index is byte address bits 9:2; timer banks are 16 words apart.
// A read at a timer's target offset returns its count, not the target.
//**********************************************************************

package timer_pkg;

   localparam int unsigned DATA_W          = 32;
   localparam int unsigned CYC_W           = 64;
   localparam int unsigned NUM_TIMERS      = 4;
   localparam int unsigned ADDR_W          = 10;
   localparam int unsigned WORD_IDX_W      = 8;
   // Low word-index bits that select a register inside a timer bank
   localparam int unsigned BANK_OFF_W      = 4;
   // Read selector: 0 is the cycle counter, n+1 is timer n
   localparam int unsigned RD_SEL_W        = 3;

   localparam logic [DATA_W-1:0] TARGET_RESET = 32'h1000_0000;
   localparam logic [WORD_IDX_W-1:0] TIMER_BANK_BASE = 8'd16;

   typedef enum logic [1:0]
   {
      IDLE,
      RESP_WRITE,
      RESP_LO,
      RESP_HI
   } bus_state_e;

   // Cycle counter word offsets
   typedef enum logic [WORD_IDX_W-1:0]
   {
      CYC_START   = 8'd0,
      CYC_STOP    = 8'd1,
      CYC_CLEAR   = 8'd2,
      CYC_READ_LO = 8'd3,
      CYC_READ_HI = 8'd4
   } cyc_reg_e;

   // Offsets inside one timer bank
   typedef enum logic [BANK_OFF_W-1:0]
   {
      TMR_START  = 4'd0,
      TMR_STOP   = 4'd1,
      TMR_CLEAR  = 4'd2,
      TMR_TARGET = 4'd3
   } tmr_reg_e;

   // Word index of the first register of timer n
   function automatic logic [WORD_IDX_W-1:0] tmr_bank_idx(input int unsigned n);
      return WORD_IDX_W'(TIMER_BANK_BASE * (n + 1));
   endfunction

endpackage

// ==== hdl/cycle_counter.sv ====
//**********************************************************************
// Free-running 64-bit cycle counter with run/idle control.
// Counting starts on the edge after the start strobe.
// Clear wins over counting in either state.
//**********************************************************************

`timescale 1ns/10ps

module cycle_counter
(
   input  logic                          clk_i,
   input  logic                          rst_ni,
   input  logic                          start_i,
   input  logic                          stop_i,
   input  logic                          clear_i,
   output logic [timer_pkg::CYC_W-1:0]   count_o
);

   typedef enum logic
   {
      CNT_IDLE,
      CNT_RUN
   } run_state_e;

   run_state_e                   state_q, state_d;
   logic [timer_pkg::CYC_W-1:0]  count_q;

   // Run/idle transitions
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         CNT_IDLE: if (start_i) state_d = CNT_RUN;
         CNT_RUN:  if (stop_i)  state_d = CNT_IDLE;
         default:  state_d = CNT_IDLE;
      endcase
   end

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= CNT_IDLE;
         count_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (clear_i)
            count_q <= '0;
         else if (state_q == CNT_RUN)
            count_q <= count_q + 1'b1;
      end
   end

   assign count_o = count_q;

endmodule

// ==== hdl/event_timer/event_timer.sv ====
//**********************************************************************
// One 32-bit event timer. Event is high while count equals target,
// and the count wraps to zero on the following edge.
// With target T a running timer pulses every T+1 cycles.
//**********************************************************************

`timescale 1ns/10ps

module event_timer
(
   input  logic                          clk_i,
   input  logic                          rst_ni,
   input  logic                          start_i,
   input  logic                          stop_i,
   input  logic                          clear_i,
   input  logic                          target_we_i,
   input  logic [timer_pkg::DATA_W-1:0]  target_i,
   output logic [timer_pkg::DATA_W-1:0]  count_o,
   output logic                          event_o
);

   logic                          run_q;
   logic [timer_pkg::DATA_W-1:0]  target_q;
   logic [timer_pkg::DATA_W-1:0]  count_q;
   logic                          hit;

   assign hit = (count_q == target_q);

   // Run flag, start takes priority over stop
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         run_q <= 1'b0;
      else if (start_i)
         run_q <= 1'b1;
      else if (stop_i)
         run_q <= 1'b0;
   end

   // Target register, reset well above any test count
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         target_q <= timer_pkg::TARGET_RESET;
      else if (target_we_i)
         target_q <= target_i;
   end

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         count_q <= '0;
      else if (clear_i || hit)
         count_q <= '0;
      else if (run_q)
         count_q <= count_q + 1'b1;
   end

   assign count_o = count_q;
   assign event_o = hit;

endmodule

// ==== hdl/periph_decoder.sv ====
//**********************************************************************
// Bus slave: grants while idle, answers exactly one cycle later.
// Any access to a command address is a command, read or write.
// Read data are sampled from the live counts in the response cycle.
//**********************************************************************

`timescale 1ns/10ps

module periph_decoder
(
   input  logic                                  clk_i,
   input  logic                                  rst_ni,

   input  logic                                  req_i,
   input  logic [timer_pkg::ADDR_W-1:0]          addr_i,
   input  logic                                  we_i,
   input  logic [timer_pkg::DATA_W-1:0]          wdata_i,
   output logic                                  gnt_o,
   output logic                                  rvalid_o,
   output logic [timer_pkg::DATA_W-1:0]          rdata_o,

   input  logic [timer_pkg::CYC_W-1:0]           cyc_count_i,
   input  logic [timer_pkg::NUM_TIMERS-1:0][timer_pkg::DATA_W-1:0] tmr_count_i,

   output logic                                  cyc_start_o,
   output logic                                  cyc_stop_o,
   output logic                                  cyc_clear_o,
   output logic [timer_pkg::NUM_TIMERS-1:0]      tmr_start_o,
   output logic [timer_pkg::NUM_TIMERS-1:0]      tmr_stop_o,
   output logic [timer_pkg::NUM_TIMERS-1:0]      tmr_clear_o,
   output logic [timer_pkg::NUM_TIMERS-1:0]      tmr_target_we_o,
   output logic [timer_pkg::DATA_W-1:0]          target_wdata_o
);

   timer_pkg::bus_state_e                state_q, state_d;
   logic [timer_pkg::RD_SEL_W-1:0]       rd_sel_q, rd_sel_d;

   logic [timer_pkg::WORD_IDX_W-1:0]     word_idx;
   logic [timer_pkg::WORD_IDX_W-1:0]     bank_idx;
   logic [timer_pkg::BANK_OFF_W-1:0]     bank_off;

   // Word index and its split into bank and offset
   assign word_idx = addr_i[timer_pkg::ADDR_W-1:2];
   assign bank_idx = {word_idx[timer_pkg::WORD_IDX_W-1:timer_pkg::BANK_OFF_W],
                      {timer_pkg::BANK_OFF_W{1'b0}}};
   assign bank_off = word_idx[timer_pkg::BANK_OFF_W-1:0];

   // One shared data path for all target registers
   assign target_wdata_o = wdata_i;

   //*******************************************************************
   // Accept and decode
   //*******************************************************************

   always_comb
   begin
      state_d         = timer_pkg::IDLE;
      rd_sel_d        = rd_sel_q;
      cyc_start_o     = 1'b0;
      cyc_stop_o      = 1'b0;
      cyc_clear_o     = 1'b0;
      tmr_start_o     = '0;
      tmr_stop_o      = '0;
      tmr_clear_o     = '0;
      tmr_target_we_o = '0;

      if (state_q == timer_pkg::IDLE && req_i)
      begin
         case (word_idx)
            timer_pkg::CYC_START:
            begin
               cyc_start_o = 1'b1;
               state_d     = timer_pkg::RESP_WRITE;
            end
            timer_pkg::CYC_STOP:
            begin
               cyc_stop_o = 1'b1;
               state_d    = timer_pkg::RESP_WRITE;
            end
            timer_pkg::CYC_CLEAR:
            begin
               cyc_clear_o = 1'b1;
               state_d     = timer_pkg::RESP_WRITE;
            end
            timer_pkg::CYC_READ_LO:
            begin
               rd_sel_d = '0;
               state_d  = we_i ? timer_pkg::RESP_WRITE : timer_pkg::RESP_LO;
            end
            timer_pkg::CYC_READ_HI:
            begin
               state_d = we_i ? timer_pkg::RESP_WRITE : timer_pkg::RESP_HI;
            end
            default:
            begin
               // Timer banks; anything else stays unanswered
               for (int n = 0; n < timer_pkg::NUM_TIMERS; n++)
               begin
                  if (bank_idx == timer_pkg::tmr_bank_idx(n))
                  begin
                     case (bank_off)
                        timer_pkg::TMR_START:
                        begin
                           tmr_start_o[n] = 1'b1;
                           state_d        = timer_pkg::RESP_WRITE;
                        end
                        timer_pkg::TMR_STOP:
                        begin
                           tmr_stop_o[n] = 1'b1;
                           state_d       = timer_pkg::RESP_WRITE;
                        end
                        timer_pkg::TMR_CLEAR:
                        begin
                           tmr_clear_o[n] = 1'b1;
                           state_d        = timer_pkg::RESP_WRITE;
                        end
                        timer_pkg::TMR_TARGET:
                        begin
                           tmr_target_we_o[n] = we_i;
                           rd_sel_d = timer_pkg::RD_SEL_W'(n + 1);
                           state_d  = we_i ? timer_pkg::RESP_WRITE : timer_pkg::RESP_LO;
                        end
                        default:
                        begin
                           state_d = timer_pkg::IDLE;
                        end
                     endcase
                  end
               end
            end
         endcase
      end
   end

   //*******************************************************************
   // Response
   //*******************************************************************

   assign gnt_o    = (state_q == timer_pkg::IDLE);
   assign rvalid_o = (state_q != timer_pkg::IDLE);

   always_comb
   begin
      rdata_o = '0;
      if (state_q == timer_pkg::RESP_HI)
      begin
         rdata_o = cyc_count_i[timer_pkg::CYC_W-1:timer_pkg::DATA_W];
      end
      else if (state_q == timer_pkg::RESP_LO)
      begin
         rdata_o = cyc_count_i[timer_pkg::DATA_W-1:0];
         for (int n = 0; n < timer_pkg::NUM_TIMERS; n++)
         begin
            if (rd_sel_q == timer_pkg::RD_SEL_W'(n + 1))
               rdata_o = tmr_count_i[n];
         end
      end
   end

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q  <= timer_pkg::IDLE;
         rd_sel_q <= '0;
      end
      else
      begin
         state_q  <= state_d;
         rd_sel_q <= rd_sel_d;
      end
   end

endmodule

// ==== hdl/timer_unit_top.sv ====
//**********************************************************************
// Timer peripheral top: bus decoder, 64-bit cycle counter and four
// 32-bit event timers. Single bus master, no response stalling.
// Unmapped addresses are granted but never answered.
//**********************************************************************

`timescale 1ns/10ps

module timer_unit_top
(
   input  logic                                  clk_i,
   input  logic                                  rst_ni,

   input  logic                                  req_i,
   input  logic [timer_pkg::ADDR_W-1:0]          addr_i,
   input  logic                                  we_i,
   input  logic [timer_pkg::DATA_W-1:0]          wdata_i,
   output logic                                  gnt_o,
   output logic                                  rvalid_o,
   output logic [timer_pkg::DATA_W-1:0]          rdata_o,

   output logic [timer_pkg::NUM_TIMERS-1:0]      event_o
);

   // Strobes from the decode stage
   logic                                         cyc_start;
   logic                                         cyc_stop;
   logic                                         cyc_clear;
   logic [timer_pkg::NUM_TIMERS-1:0]             tmr_start;
   logic [timer_pkg::NUM_TIMERS-1:0]             tmr_stop;
   logic [timer_pkg::NUM_TIMERS-1:0]             tmr_clear;
   logic [timer_pkg::NUM_TIMERS-1:0]             tmr_target_we;
   logic [timer_pkg::DATA_W-1:0]                 target_wdata;

   // Counts fed back for reads
   logic [timer_pkg::CYC_W-1:0]                  cyc_count;
   logic [timer_pkg::NUM_TIMERS-1:0][timer_pkg::DATA_W-1:0] tmr_count;

   //*******************************************************************
   // Bus decode stage
   //*******************************************************************

   periph_decoder u_decoder
   (
      .clk_i           ( clk_i         ),
      .rst_ni          ( rst_ni        ),
      .req_i           ( req_i         ),
      .addr_i          ( addr_i        ),
      .we_i            ( we_i          ),
      .wdata_i         ( wdata_i       ),
      .gnt_o           ( gnt_o         ),
      .rvalid_o        ( rvalid_o      ),
      .rdata_o         ( rdata_o       ),
      .cyc_count_i     ( cyc_count     ),
      .tmr_count_i     ( tmr_count     ),
      .cyc_start_o     ( cyc_start     ),
      .cyc_stop_o      ( cyc_stop      ),
      .cyc_clear_o     ( cyc_clear     ),
      .tmr_start_o     ( tmr_start     ),
      .tmr_stop_o      ( tmr_stop      ),
      .tmr_clear_o     ( tmr_clear     ),
      .tmr_target_we_o ( tmr_target_we ),
      .target_wdata_o  ( target_wdata  )
   );

   //*******************************************************************
   // Counting stage
   //*******************************************************************

   cycle_counter u_cycle_counter
   (
      .clk_i   ( clk_i     ),
      .rst_ni  ( rst_ni    ),
      .start_i ( cyc_start ),
      .stop_i  ( cyc_stop  ),
      .clear_i ( cyc_clear ),
      .count_o ( cyc_count )
   );

   for (genvar n = 0; n < timer_pkg::NUM_TIMERS; n++)
   begin : g_timer
      event_timer u_event_timer
      (
         .clk_i       ( clk_i            ),
         .rst_ni      ( rst_ni           ),
         .start_i     ( tmr_start[n]     ),
         .stop_i      ( tmr_stop[n]      ),
         .clear_i     ( tmr_clear[n]     ),
         .target_we_i ( tmr_target_we[n] ),
         .target_i    ( target_wdata     ),
         .count_o     ( tmr_count[n]     ),
         .event_o     ( event_o[n]       )
      );
   end

endmodule

// ==== bench/timer_unit_assertions.sv ====
//**********************************************************************
// Bus protocol properties of the timer peripheral, bound to the top.
// Assumes every granted request hits a mapped address.
//**********************************************************************

`timescale 1ns/10ps

module timer_unit_assertions
(
   input  logic  clk_i,
   input  logic  rst_ni,
   input  logic  req_i,
   input  logic  gnt_i,
   input  logic  rvalid_i
);

   logic        accepted;
   int unsigned err_count = 0;

   assign accepted = req_i && gnt_i;

   // Response exactly one cycle after acceptance
   a_resp_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
      accepted |=> rvalid_i)
   else
   begin
      err_count++;
      $error("Accepted request was not answered in the next cycle");
   end

   a_resp_needs_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !accepted |=> !rvalid_i)
   else
   begin
      err_count++;
      $error("Response without an accepted request one cycle earlier");
   end

   a_no_grant_in_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rvalid_i |-> !gnt_i)
   else
   begin
      err_count++;
      $error("Grant high during a response cycle");
   end

   a_single_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rvalid_i |=> !rvalid_i)
   else
   begin
      err_count++;
      $error("Response valid high in two cycles in a row");
   end

endmodule

bind timer_unit_top timer_unit_assertions u_assertions
(
   .clk_i    ( clk_i    ),
   .rst_ni   ( rst_ni   ),
   .req_i    ( req_i    ),
   .gnt_i    ( gnt_o    ),
   .rvalid_i ( rvalid_o )
);

// ==== bench/timer_unit_tb.sv ====
//**********************************************************************
// Testbench for the timer peripheral. A table of bus steps is run in
// order; each step holds its name, operation and expected check.
// Event timer targets are random in 4..35 from a fixed xorshift seed.
// Unmapped addresses are never used as they get no response.
//**********************************************************************

`timescale 1ns/10ps

module timer_unit_tb;

   localparam int unsigned TIMEOUT_CYCLES = 4000;

   // Step operations
   localparam int OP_WRITE  = 0;
   localparam int OP_READ   = 1;
   localparam int OP_WAIT   = 2;
   localparam int OP_PERIOD = 3;

   // Check kinds
   localparam int CHK_NONE  = 0;
   localparam int CHK_EQ    = 1;
   localparam int CHK_DELTA = 2;
   localparam int CHK_SAME  = 3;
   localparam int CHK_QUIET = 4;
   localparam int CHK_GAP   = 5;

   logic                                clk;
   logic                                rst_n;
   logic                                req;
   logic [timer_pkg::ADDR_W-1:0]        addr;
   logic                                we;
   logic [timer_pkg::DATA_W-1:0]        wdata;
   logic                                gnt;
   logic                                rvalid;
   logic [timer_pkg::DATA_W-1:0]        rdata;
   logic [timer_pkg::NUM_TIMERS-1:0]    evt;

   int unsigned                         cycle_cnt = 0;
   logic [timer_pkg::DATA_W-1:0]        prev_data;
   int unsigned                         prev_resp;

   // Stimulus table, one entry per index
   string                               step_name[$];
   int                                  step_op[$];
   logic [timer_pkg::ADDR_W-1:0]        step_addr[$];
   logic [timer_pkg::DATA_W-1:0]        step_wdata[$];
   int                                  step_chk[$];
   logic [timer_pkg::DATA_W-1:0]        step_exp[$];

   timer_unit_top dut0
   (
      .clk_i    ( clk    ),
      .rst_ni   ( rst_n  ),
      .req_i    ( req    ),
      .addr_i   ( addr   ),
      .we_i     ( we     ),
      .wdata_i  ( wdata  ),
      .gnt_o    ( gnt    ),
      .rvalid_o ( rvalid ),
      .rdata_o  ( rdata  ),
      .event_o  ( evt    )
   );

   always #20 clk = ~clk;

   task automatic report_error(input string line);
      $display("%s", line);
      $display("TESTBENCH FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic value_error(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      report_error($sformatf("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act));
   endtask

   // Cycle count and timeout
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES)
         report_error($sformatf("Timeout: tests still running after %0d cycles",
                                TIMEOUT_CYCLES));
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [timer_pkg::ADDR_W-1:0] cyc_addr(input logic [7:0] off);
      return {off, 2'b00};
   endfunction

   function automatic logic [timer_pkg::ADDR_W-1:0] tmr_addr(input int unsigned n,
                                                            input logic [3:0] off);
      logic [7:0] idx;
      idx = timer_pkg::tmr_bank_idx(n) + {4'b0000, off};
      return {idx, 2'b00};
   endfunction

   task automatic add_step(input string name, input int op,
                           input logic [timer_pkg::ADDR_W-1:0] a, input logic [31:0] d,
                           input int chk, input logic [31:0] exp);
      step_name.push_back(name);
      step_op.push_back(op);
      step_addr.push_back(a);
      step_wdata.push_back(d);
      step_chk.push_back(chk);
      step_exp.push_back(exp);
   endtask

   //*******************************************************************
   // Bus access and event monitors
   //*******************************************************************

   task automatic bus_access(input logic write, input logic [timer_pkg::ADDR_W-1:0] a,
                             input logic [31:0] d, output logic [31:0] rd,
                             output int unsigned resp_cycle);
      int unsigned waited;
      @(posedge clk);
      req   <= 1'b1;
      addr  <= a;
      we    <= write;
      wdata <= d;
      // Grant is combinational while idle
      @(negedge clk);
      while (!gnt)
         @(negedge clk);
      @(posedge clk);
      req <= 1'b0;
      waited = 0;
      @(negedge clk);
      while (!rvalid)
      begin
         waited++;
         @(negedge clk);
      end
      assert (waited == 0 && !gnt)
      else report_error("Response did not come one cycle after acceptance with grant low");
      rd = rdata;
      resp_cycle = cycle_cnt;
      @(negedge clk);
      assert (!rvalid)
      else report_error("Response valid stayed high for more than one cycle");
   endtask

   task automatic wait_event_rise(input logic [1:0] n, output int unsigned at);
      logic prev;
      @(negedge clk);
      prev = evt[n];
      @(negedge clk);
      while (!(evt[n] && !prev))
      begin
         prev = evt[n];
         @(negedge clk);
      end
      at = cycle_cnt;
   endtask

   task automatic watch_quiet(input string name, input int unsigned cycles,
                              input logic [3:0] mask);
      repeat (cycles)
      begin
         @(negedge clk);
         assert ((evt & mask) == 4'b0000)
         else value_error(name, 32'h0, 32'(evt & mask));
      end
   endtask

   task automatic check_data(input string name, input int chk, input logic [31:0] exp,
                             input logic [31:0] rd, input int unsigned resp);
      int unsigned gap;
      gap = resp - prev_resp;
      case (chk)
         CHK_EQ:
            assert (rd == exp) else value_error(name, exp, rd);
         CHK_DELTA:
         begin
            assert (gap >= 2)
            else report_error($sformatf("%s: responses only %0d cycles apart", name, gap));
            assert (rd - prev_data == gap) else value_error(name, prev_data + gap, rd);
         end
         CHK_SAME:
            assert (rd == prev_data) else value_error(name, prev_data, rd);
         default: ;
      endcase
   endtask

   task automatic run_step(input int i);
      logic [31:0] rd;
      int unsigned resp;
      int unsigned first;
      int unsigned second;
      case (step_op[i])
         OP_WRITE:
         begin
            bus_access(1'b1, step_addr[i], step_wdata[i], rd, resp);
            check_data(step_name[i], step_chk[i], step_exp[i], rd, resp);
         end
         OP_READ:
         begin
            bus_access(1'b0, step_addr[i], 32'h0, rd, resp);
            check_data(step_name[i], step_chk[i], step_exp[i], rd, resp);
            prev_data = rd;
            prev_resp = resp;
         end
         OP_WAIT:
            watch_quiet(step_name[i], step_wdata[i], step_exp[i][3:0]);
         OP_PERIOD:
         begin
            wait_event_rise(step_wdata[i][1:0], first);
            wait_event_rise(step_wdata[i][1:0], second);
            assert (second - first == step_exp[i])
            else value_error(step_name[i], step_exp[i], 32'(second - first));
         end
         default:
            report_error("Unknown operation in the stimulus table");
      endcase
   endtask

   //*******************************************************************
   // Stimulus table
   //*******************************************************************

   task automatic build_table();
      logic [31:0] rnd;
      logic [31:0] tgt[timer_pkg::NUM_TIMERS];
      rnd = 32'h6a9a;
      add_step("reset cycle lo", OP_READ, cyc_addr(8'd3), 0, CHK_EQ, 0);
      add_step("reset cycle hi", OP_READ, cyc_addr(8'd4), 0, CHK_EQ, 0);
      for (int unsigned n = 0; n < timer_pkg::NUM_TIMERS; n++)
         add_step($sformatf("reset timer%0d count", n), OP_READ, tmr_addr(n, 4'd3), 0,
                  CHK_EQ, 0);
      add_step("reset events low", OP_WAIT, 0, 32'd20, CHK_QUIET, 32'hF);

      add_step("cycle start", OP_WRITE, cyc_addr(8'd0), 0, CHK_EQ, 0);
      add_step("cycle run first", OP_READ, cyc_addr(8'd3), 0, CHK_NONE, 0);
      add_step("cycle run second", OP_READ, cyc_addr(8'd3), 0, CHK_DELTA, 0);
      add_step("cycle stop", OP_WRITE, cyc_addr(8'd1), 0, CHK_EQ, 0);
      add_step("cycle stopped first", OP_READ, cyc_addr(8'd3), 0, CHK_NONE, 0);
      add_step("cycle stopped second", OP_READ, cyc_addr(8'd3), 0, CHK_SAME, 0);
      add_step("cycle stopped hi", OP_READ, cyc_addr(8'd4), 0, CHK_EQ, 0);
      add_step("cycle clear", OP_WRITE, cyc_addr(8'd2), 0, CHK_EQ, 0);
      add_step("cycle cleared", OP_READ, cyc_addr(8'd3), 0, CHK_EQ, 0);

      // Period, stop and restart of every timer in turn
      for (int unsigned n = 0; n < timer_pkg::NUM_TIMERS; n++)
      begin
         rnd = xorshift32(rnd);
         tgt[n] = (rnd & 32'h1F) + 32'd4;
         add_step($sformatf("timer%0d target", n), OP_WRITE, tmr_addr(n, 4'd3), tgt[n],
                  CHK_EQ, 0);
         add_step($sformatf("timer%0d clear", n), OP_WRITE, tmr_addr(n, 4'd2), 0, CHK_EQ, 0);
         add_step($sformatf("timer%0d start", n), OP_WRITE, tmr_addr(n, 4'd0), 0, CHK_EQ, 0);
         add_step($sformatf("timer%0d period", n), OP_PERIOD, 0, n, CHK_GAP, tgt[n] + 32'd1);
         add_step($sformatf("timer%0d stop", n), OP_WRITE, tmr_addr(n, 4'd1), 0, CHK_EQ, 0);
         add_step($sformatf("timer%0d stopped quiet", n), OP_WAIT, 0,
                  32'd2 * (tgt[n] + 32'd1), CHK_QUIET, 32'h1 << n);
         add_step($sformatf("timer%0d held first", n), OP_READ, tmr_addr(n, 4'd3), 0,
                  CHK_NONE, 0);
         add_step($sformatf("timer%0d held second", n), OP_READ, tmr_addr(n, 4'd3), 0,
                  CHK_SAME, 0);
         add_step($sformatf("timer%0d restart", n), OP_WRITE, tmr_addr(n, 4'd0), 0, CHK_EQ, 0);
         add_step($sformatf("timer%0d period again", n), OP_PERIOD, 0, n, CHK_GAP,
                  tgt[n] + 32'd1);
         add_step($sformatf("timer%0d final stop", n), OP_WRITE, tmr_addr(n, 4'd1), 0,
                  CHK_EQ, 0);
      end

      // Only timer 2 runs
      add_step("solo timer2 start", OP_WRITE, tmr_addr(2, 4'd0), 0, CHK_EQ, 0);
      add_step("solo timer1 first", OP_READ, tmr_addr(1, 4'd3), 0, CHK_NONE, 0);
      add_step("solo timer2 clear", OP_WRITE, tmr_addr(2, 4'd2), 0, CHK_EQ, 0);
      add_step("solo timer1 second", OP_READ, tmr_addr(1, 4'd3), 0, CHK_SAME, 0);
      add_step("solo others quiet", OP_WAIT, 0, 32'd3 * (tgt[2] + 32'd1), CHK_QUIET, 32'hB);
      add_step("solo timer2 period", OP_PERIOD, 0, 2, CHK_GAP, tgt[2] + 32'd1);
      add_step("solo timer2 stop", OP_WRITE, tmr_addr(2, 4'd1), 0, CHK_EQ, 0);
   endtask

   initial
   begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      req       = 1'b0;
      addr      = '0;
      we        = 1'b0;
      wdata     = '0;
      prev_data = '0;
      prev_resp = 0;
      build_table();
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < step_name.size(); i++)
         run_step(i);
      if (dut0.u_assertions.err_count == 0)
      begin
         $display("TESTBENCH PASSED");
         $finish;
      end
      else
      begin
         report_error("A bus protocol assertion failed during the run");
      end
   end

endmodule

// ==== build.f ====
common/timer_pkg.sv
hdl/cycle_counter.sv
hdl/event_timer/event_timer.sv
hdl/periph_decoder.sv
hdl/timer_unit_top.sv
bench/timer_unit_assertions.sv
bench/timer_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the timer testbench with Verilator.
# The exit status is non-zero unless the pass line shows up.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module timer_unit_tb --Mdir obj_dir -o timer_unit_sim &&
   ./obj_dir/timer_unit_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
   echo "Simulation result: pass" ||
   { echo "Simulation result: fail"; exit 1; }
